// ==== csr_data.sv ====
`timescale 1ns/100ps

module csr_data
    import csr_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    input  logic [csr_addr_bits-1:0]    read_addr,
    input  logic [wid_bits-1:0]         read_wid,
    output logic [xlen-1:0]             read_data,

    input  logic                        write_enable,
    input  logic [csr_addr_bits-1:0]    write_addr,
    input  logic [wid_bits-1:0]         write_wid,
    input  logic [xlen-1:0]             write_data,

    input  logic                        fpu_valid,
    input  logic [wid_bits-1:0]         fpu_wid,
    input  logic [ffg_bits-1:0]         fpu_fflags,
    input  logic [wid_bits-1:0]         fpu_read_wid,
    output logic [frm_bits-1:0]         fpu_frm,

    input  logic                        commit_valid,
    input  logic [commit_size_bits-1:0] commit_size,
    input  logic                        busy
);
    fcsr_u           fcsr_r [num_warps];
    logic [xlen-1:0] mstatus_r;
    logic [xlen-1:0] mie_r;
    logic [xlen-1:0] mtvec_r;
    logic [xlen-1:0] mscratch_r;
    logic [xlen-1:0] mepc_r;
    logic [63:0]     mcycle_r;
    logic [63:0]     minstret_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_warps; i++)
                fcsr_r[i] <= '0;
            mstatus_r  <= '0;
            mie_r      <= '0;
            mtvec_r    <= '0;
            mscratch_r <= '0;
            mepc_r     <= '0;
        end else begin
            if (fpu_valid)
                fcsr_r[fpu_wid].f.fflags <= fpu_fflags;
            // later assignment, so an instruction write beats the fpu
            if (write_enable) begin
                case (write_addr)
                    csr_fflags:   fcsr_r[write_wid].f.fflags <= write_data[ffg_bits-1:0];
                    csr_frm:      fcsr_r[write_wid].f.frm    <= write_data[frm_bits-1:0];
                    csr_fcsr:     fcsr_r[write_wid].raw      <=
                                      write_data[frm_bits+ffg_bits-1:0];
                    csr_mstatus:  mstatus_r  <= write_data;
                    csr_mie:      mie_r      <= write_data;
                    csr_mtvec:    mtvec_r    <= write_data;
                    csr_mscratch: mscratch_r <= write_data;
                    csr_mepc:     mepc_r     <= write_data;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle_r   <= '0;
            minstret_r <= '0;
        end else begin
            if (busy)
                mcycle_r <= mcycle_r + 64'd1;
            if (commit_valid)
                minstret_r <= minstret_r + 64'(commit_size);
        end
    end

    always_comb begin
        case (read_addr)
            csr_fflags:     read_data = xlen'(fcsr_r[read_wid].f.fflags);
            csr_frm:        read_data = xlen'(fcsr_r[read_wid].f.frm);
            csr_fcsr:       read_data = xlen'(fcsr_r[read_wid].raw);

            csr_wid:        read_data = xlen'(read_wid);
            csr_gwid,
            csr_mhartid:    read_data = xlen'(core_id * num_warps) + xlen'(read_wid);
            csr_nw:         read_data = xlen'(num_warps);

            csr_mstatus:    read_data = mstatus_r;
            csr_misa:       read_data = isa_code;
            csr_mie:        read_data = mie_r;
            csr_mtvec:      read_data = mtvec_r;
            csr_mscratch:   read_data = mscratch_r;
            csr_mepc:       read_data = mepc_r;

            csr_mcycle:     read_data = mcycle_r[31:0];
            csr_mcycle_h:   read_data = mcycle_r[63:32];
            csr_minstret:   read_data = minstret_r[31:0];
            csr_minstret_h: read_data = minstret_r[63:32];

            default:        read_data = '0;
        endcase
    end

    assign fpu_frm = fcsr_r[fpu_read_wid].f.frm; // side port for the fpu

endmodule

// ==== csr_decode.sv ====
`timescale 1ns/100ps

module csr_decode
    import csr_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    input  logic [wid_bits-1:0] instr_wid,
    input  logic [31:0]         rs1_data,
    csr_req_if.decode           req
);
    logic                valid_r;
    logic [31:0]         instr_r;
    logic [wid_bits-1:0] wid_r;
    logic [31:0]         rs1_r;

    logic [2:0] funct3;
    logic [4:0] rs1_field;
    logic       bad_f3;
    logic       known;
    logic       read_only;

    always_ff @(posedge clk) begin
        if (reset)
            valid_r <= 1'b0;
        else
            valid_r <= instr_valid;
        instr_r <= instr;
        wid_r   <= instr_wid;
        rs1_r   <= rs1_data;
    end

    assign funct3    = instr_r[14:12];
    assign rs1_field = instr_r[19:15];

    always_comb begin
        bad_f3 = 1'b0;
        case (funct3)
            f3_rw, f3_rwi: req.op = op_rw;
            f3_rs, f3_rsi: req.op = op_rs;
            f3_rc, f3_rci: req.op = op_rc;
            default: begin // funct3 0 and 4
                req.op = op_rw;
                bad_f3 = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (req.addr)
            csr_fflags, csr_frm, csr_fcsr,
            csr_mstatus, csr_misa, csr_mie, csr_mtvec, csr_mscratch, csr_mepc,
            csr_mcycle, csr_minstret, csr_mcycle_h, csr_minstret_h,
            csr_mhartid, csr_wid, csr_gwid, csr_nw: known = 1'b1;
            default:                                 known = 1'b0;
        endcase
    end

    // counters and misa are read-only here as well
    assign read_only = (req.addr[11:10] == 2'b11) || (req.addr == csr_misa)
                    || (req.addr == csr_mcycle) || (req.addr == csr_mcycle_h)
                    || (req.addr == csr_minstret) || (req.addr == csr_minstret_h);

    assign req.valid    = valid_r;
    assign req.wid      = wid_r;
    assign req.addr     = instr_r[31:20];
    assign req.rd       = instr_r[11:7];
    assign req.operand  = funct3[2] ? xlen'(rs1_field) : rs1_r;
    assign req.write_en = (req.op == op_rw) || (rs1_field != 5'd0);
    assign req.illegal  = (instr_r[6:0] != opcode_system) || bad_f3 || !known
                       || (req.write_en && read_only);

endmodule

// ==== csr_execute.sv ====
`timescale 1ns/100ps

module csr_execute
    import csr_pkg::*;
(
    csr_req_if.execute               req,

    output logic [csr_addr_bits-1:0] read_addr,
    output logic [wid_bits-1:0]      read_wid,
    input  logic [xlen-1:0]          read_data,

    output logic                     write_enable,
    output logic [csr_addr_bits-1:0] write_addr,
    output logic [wid_bits-1:0]      write_wid,
    output logic [xlen-1:0]          write_data,

    output logic                     ex_valid,
    output logic [wid_bits-1:0]      ex_wid,
    output logic [4:0]               ex_rd,
    output logic [xlen-1:0]          ex_old_data,
    output logic                     ex_illegal
);
    logic [xlen-1:0] new_data;

    // read-modify-write on the current value
    always_comb begin
        case (req.op)
            op_rw:   new_data = req.operand;
            op_rs:   new_data = read_data | req.operand;
            op_rc:   new_data = read_data & ~req.operand;
            default: new_data = read_data;
        endcase
    end

    assign read_addr = req.addr;
    assign read_wid  = req.wid;

    assign write_enable = req.valid && req.write_en && !req.illegal;
    assign write_addr   = req.addr;
    assign write_wid    = req.wid;
    assign write_data   = new_data;

    assign ex_valid    = req.valid;
    assign ex_wid      = req.wid;
    assign ex_rd       = req.rd;
    assign ex_old_data = read_data; // value before this write
    assign ex_illegal  = req.illegal;

endmodule

// ==== csr_pkg.sv ====
package csr_pkg;

    localparam int xlen             = 32;
    localparam int num_warps        = 4;
    localparam int wid_bits         = 2;
    localparam int csr_addr_bits    = 12;
    localparam int core_id          = 0;
    localparam int ffg_bits         = 5;
    localparam int frm_bits         = 3;
    localparam int commit_size_bits = 3;

    // floating point, per warp
    localparam logic [csr_addr_bits-1:0] csr_fflags     = 12'h001;
    localparam logic [csr_addr_bits-1:0] csr_frm        = 12'h002;
    localparam logic [csr_addr_bits-1:0] csr_fcsr       = 12'h003;

    localparam logic [csr_addr_bits-1:0] csr_mstatus    = 12'h300;
    localparam logic [csr_addr_bits-1:0] csr_misa       = 12'h301;
    localparam logic [csr_addr_bits-1:0] csr_mie        = 12'h304;
    localparam logic [csr_addr_bits-1:0] csr_mtvec      = 12'h305;
    localparam logic [csr_addr_bits-1:0] csr_mscratch   = 12'h340;
    localparam logic [csr_addr_bits-1:0] csr_mepc       = 12'h341;

    localparam logic [csr_addr_bits-1:0] csr_mcycle     = 12'hB00;
    localparam logic [csr_addr_bits-1:0] csr_minstret   = 12'hB02;
    localparam logic [csr_addr_bits-1:0] csr_mcycle_h   = 12'hB80;
    localparam logic [csr_addr_bits-1:0] csr_minstret_h = 12'hB82;

    localparam logic [csr_addr_bits-1:0] csr_mhartid    = 12'hF14;
    localparam logic [csr_addr_bits-1:0] csr_wid        = 12'hCC0;
    localparam logic [csr_addr_bits-1:0] csr_gwid       = 12'hCC1;
    localparam logic [csr_addr_bits-1:0] csr_nw         = 12'hFC1;

    localparam logic [xlen-1:0] isa_code      = 32'h4000_1120; // rv32imf
    localparam logic [6:0]      opcode_system = 7'b1110011;

    localparam logic [2:0] f3_rw  = 3'd1;
    localparam logic [2:0] f3_rs  = 3'd2;
    localparam logic [2:0] f3_rc  = 3'd3;
    localparam logic [2:0] f3_rwi = 3'd5;
    localparam logic [2:0] f3_rsi = 3'd6;
    localparam logic [2:0] f3_rci = 3'd7;

    typedef enum logic [1:0] {op_rw, op_rs, op_rc} csr_op_e;

    // fcsr byte, seen whole or as frm:fflags
    typedef union packed {
        logic [frm_bits+ffg_bits-1:0] raw;
        struct packed {
            logic [frm_bits-1:0] frm;
            logic [ffg_bits-1:0] fflags;
        } f;
    } fcsr_u;

endpackage

// ==== csr_req_if.sv ====
`timescale 1ns/100ps

interface csr_req_if
    import csr_pkg::*;
();
    logic                     valid;     // one-cycle strobe
    logic [wid_bits-1:0]      wid;
    logic [csr_addr_bits-1:0] addr;
    csr_op_e                  op;
    logic [xlen-1:0]          operand;   // rs1 data or zero-extended uimm
    logic [4:0]               rd;
    logic                     write_en;
    logic                     illegal;

    modport decode (
        output valid, wid, addr, op, operand, rd, write_en, illegal
    );

    modport execute (
        input valid, wid, addr, op, operand, rd, write_en, illegal
    );

endinterface

// ==== csr_result.sv ====
`timescale 1ns/100ps

module csr_result
    import csr_pkg::*;
(
    input  logic                clk,
    input  logic                reset,

    input  logic                ex_valid,
    input  logic [wid_bits-1:0] ex_wid,
    input  logic [4:0]          ex_rd,
    input  logic [xlen-1:0]     ex_old_data,
    input  logic                ex_illegal,

    output logic                rsp_valid,
    output logic [wid_bits-1:0] rsp_wid,
    output logic [4:0]          rsp_rd,
    output logic [xlen-1:0]     rsp_data,
    output logic                rsp_illegal
);

    always_ff @(posedge clk) begin
        if (reset)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= ex_valid;
        rsp_wid     <= ex_wid;
        rsp_rd      <= ex_rd;
        rsp_data    <= ex_illegal ? '0 : ex_old_data; // nothing leaks on illegal
        rsp_illegal <= ex_illegal;
    end

endmodule

// ==== csr_unit.f ====
csr_pkg.sv
csr_req_if.sv
csr_decode.sv
csr_data.sv
csr_execute.sv
csr_result.sv
csr_unit.sv
csr_unit_tb.sv

// ==== csr_unit.sv ====
`timescale 1ns/100ps

module csr_unit
    import csr_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        instr_valid,
    input  logic [31:0]                 instr,
    input  logic [wid_bits-1:0]         instr_wid,
    input  logic [31:0]                 rs1_data,

    input  logic                        fpu_valid,
    input  logic [wid_bits-1:0]         fpu_wid,
    input  logic [ffg_bits-1:0]         fpu_fflags,
    input  logic [wid_bits-1:0]         fpu_read_wid,
    output logic [frm_bits-1:0]         fpu_frm,

    input  logic                        commit_valid,
    input  logic [commit_size_bits-1:0] commit_size,
    input  logic                        busy,

    output logic                        rsp_valid,
    output logic [wid_bits-1:0]         rsp_wid,
    output logic [4:0]                  rsp_rd,
    output logic [xlen-1:0]             rsp_data,
    output logic                        rsp_illegal
);
    csr_req_if req ();

    logic [csr_addr_bits-1:0] read_addr;
    logic [wid_bits-1:0]      read_wid;
    logic [xlen-1:0]          read_data;
    logic                     write_enable;
    logic [csr_addr_bits-1:0] write_addr;
    logic [wid_bits-1:0]      write_wid;
    logic [xlen-1:0]          write_data;

    logic                     ex_valid;
    logic [wid_bits-1:0]      ex_wid;
    logic [4:0]               ex_rd;
    logic [xlen-1:0]          ex_old_data;
    logic                     ex_illegal;

    csr_decode decode0 (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .instr_wid(instr_wid), .rs1_data(rs1_data), .req(req.decode)
    );

    csr_execute execute0 (
        .req(req.execute),
        .read_addr(read_addr), .read_wid(read_wid), .read_data(read_data),
        .write_enable(write_enable), .write_addr(write_addr),
        .write_wid(write_wid), .write_data(write_data),
        .ex_valid(ex_valid), .ex_wid(ex_wid), .ex_rd(ex_rd),
        .ex_old_data(ex_old_data), .ex_illegal(ex_illegal)
    );

    csr_data data0 (
        .clk(clk), .reset(reset),
        .read_addr(read_addr), .read_wid(read_wid), .read_data(read_data),
        .write_enable(write_enable), .write_addr(write_addr),
        .write_wid(write_wid), .write_data(write_data),
        .fpu_valid(fpu_valid), .fpu_wid(fpu_wid), .fpu_fflags(fpu_fflags),
        .fpu_read_wid(fpu_read_wid), .fpu_frm(fpu_frm),
        .commit_valid(commit_valid), .commit_size(commit_size), .busy(busy)
    );

    csr_result result0 (
        .clk(clk), .reset(reset),
        .ex_valid(ex_valid), .ex_wid(ex_wid), .ex_rd(ex_rd),
        .ex_old_data(ex_old_data), .ex_illegal(ex_illegal),
        .rsp_valid(rsp_valid), .rsp_wid(rsp_wid), .rsp_rd(rsp_rd),
        .rsp_data(rsp_data), .rsp_illegal(rsp_illegal)
    );

endmodule

// ==== csr_unit_tb.sv ====
`timescale 1ns/100ps

module csr_unit_tb
    import csr_pkg::*;
();
    localparam int max_rows       = 64;
    localparam int counter_cycles = 40;  // commit, busy and fpu_frm phases

    logic        clk, reset, instr_valid;
    logic [31:0] instr, rs1_data;
    logic [1:0]  instr_wid, fpu_wid, fpu_read_wid, rsp_wid;
    logic        fpu_valid, commit_valid, busy, rsp_valid, rsp_illegal;
    logic [4:0]  fpu_fflags, rsp_rd;
    logic [2:0]  fpu_frm, commit_size;
    logic [31:0] rsp_data;

    // stimulus table with expected columns filled by run_model
    logic [2:0]  r_f3   [max_rows];
    logic [11:0] r_addr [max_rows];
    logic [4:0]  r_src  [max_rows];  // rs1 field or immediate
    logic [1:0]  r_wid  [max_rows];
    logic [31:0] r_rs1  [max_rows];
    logic [7:0]  r_fpu  [max_rows];  // {valid, wid, fflags}
    logic [31:0] exp_old [max_rows];
    logic        exp_ill [max_rows];

    logic [7:0]  fcsr_m [num_warps];
    logic [31:0] mach_m [5];

    int n_rows, errors, tests, failed_tests, cycles, mon_row, mon_errs, mon_issue;
    int cycle_limit = 1000;
    int pending [$];
    int issued [$];
    bit table_phase;

    csr_unit dut0 (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .instr_wid(instr_wid), .rs1_data(rs1_data),
        .fpu_valid(fpu_valid), .fpu_wid(fpu_wid), .fpu_fflags(fpu_fflags),
        .fpu_read_wid(fpu_read_wid), .fpu_frm(fpu_frm),
        .commit_valid(commit_valid), .commit_size(commit_size), .busy(busy),
        .rsp_valid(rsp_valid), .rsp_wid(rsp_wid), .rsp_rd(rsp_rd),
        .rsp_data(rsp_data), .rsp_illegal(rsp_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors != errs_before) begin
            failed_tests++;
            $display("%s: FAILED", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic add_row(input logic [2:0] f3, input logic [11:0] a, input logic [4:0] src,
                           input logic [1:0] w, input logic [31:0] rs1, input logic [7:0] fpu);
        r_f3[n_rows]   = f3;
        r_addr[n_rows] = a;
        r_src[n_rows]  = src;
        r_wid[n_rows]  = w;
        r_rs1[n_rows]  = rs1;
        r_fpu[n_rows]  = fpu;
        n_rows++;
    endtask

    function automatic int mach_index(input logic [11:0] a);
        case (a)
            csr_mstatus:  return 0;
            csr_mie:      return 1;
            csr_mtvec:    return 2;
            csr_mscratch: return 3;
            csr_mepc:     return 4;
            default:      return -1;
        endcase
    endfunction

    function automatic logic [31:0] ref_read(input logic [11:0] a, input logic [1:0] w);
        if (mach_index(a) >= 0)
            return mach_m[mach_index(a)];
        case (a)
            csr_fflags: return {27'd0, fcsr_m[w][4:0]};
            csr_frm:    return {29'd0, fcsr_m[w][7:5]};
            csr_fcsr:   return {24'd0, fcsr_m[w]};
            csr_misa:   return isa_code;
            csr_wid:    return {30'd0, w};
            csr_gwid, csr_mhartid: return 32'(core_id * num_warps + w);
            csr_nw:     return 32'(num_warps);
            default:    return 32'd0;  // busy and commits stay low during the table
        endcase
    endfunction

    function automatic logic ref_illegal(input logic [2:0] f3, input logic [11:0] a,
                                         input logic we);
        logic known, ro;
        known = mach_index(a) >= 0;
        case (a)
            csr_fflags, csr_frm, csr_fcsr, csr_misa, csr_mcycle, csr_minstret,
            csr_mcycle_h, csr_minstret_h, csr_mhartid, csr_wid, csr_gwid, csr_nw: known = 1'b1;
            default: ;
        endcase
        ro = (a[11:10] == 2'b11) || (a == csr_misa) || (a == csr_mcycle)
          || (a == csr_mcycle_h) || (a == csr_minstret) || (a == csr_minstret_h);
        return (f3 == 3'd0) || (f3 == 3'd4) || !known || (we && ro);
    endfunction

    task automatic ref_write(input logic [11:0] a, input logic [1:0] w, input logic [31:0] d);
        if (mach_index(a) >= 0)
            mach_m[mach_index(a)] = d;
        else if (a == csr_fflags)
            fcsr_m[w][4:0] = d[4:0];
        else if (a == csr_frm)
            fcsr_m[w][7:5] = d[2:0];
        else if (a == csr_fcsr)
            fcsr_m[w] = d[7:0];
    endtask

    task automatic run_model();
        logic        pend, we, ill;
        logic [11:0] pa;
        logic [1:0]  pw;
        logic [31:0] pd, opnd, old;
        pend = 1'b0;
        pa   = '0;
        pw   = '0;
        pd   = '0;
        foreach (fcsr_m[i])
            fcsr_m[i] = '0;
        foreach (mach_m[i])
            mach_m[i] = '0;
        for (int t = 0; t < n_rows; t++) begin
            // fpu of row t shares an edge with the write of row t-1
            if (r_fpu[t][7])
                fcsr_m[r_fpu[t][6:5]][4:0] = r_fpu[t][4:0];
            if (pend)
                ref_write(pa, pw, pd);  // applied last so the instruction wins
            opnd = r_f3[t][2] ? {27'd0, r_src[t]} : r_rs1[t];
            old  = ref_read(r_addr[t], r_wid[t]);
            we   = (r_f3[t][1:0] == 2'd1) || (r_src[t] != 5'd0);
            ill  = ref_illegal(r_f3[t], r_addr[t], we);
            exp_old[t] = ill ? 32'd0 : old;
            exp_ill[t] = ill;
            pend = we && !ill;
            pa   = r_addr[t];
            pw   = r_wid[t];
            case (r_f3[t][1:0])
                2'd2:    pd = old | opnd;
                2'd3:    pd = old & ~opnd;
                default: pd = opnd;
            endcase
        end
        if (pend)
            ref_write(pa, pw, pd);
    endtask

    task automatic build_table();
        add_row(f3_rw,  csr_mstatus,  5'd1,  2'd0, $urandom(), 8'h00);
        add_row(f3_rs,  csr_mstatus,  5'd2,  2'd0, $urandom(), 8'h00);
        add_row(f3_rc,  csr_mstatus,  5'd3,  2'd0, $urandom(), 8'h00);
        add_row(f3_rs,  csr_mstatus,  5'd0,  2'd0, 32'hffff_ffff, 8'h00); // zero field means no write
        add_row(f3_rs,  csr_mstatus,  5'd0,  2'd0, 32'd0, 8'h00);
        add_row(f3_rw,  csr_mie,      5'd1,  2'd1, $urandom(), 8'h00);
        add_row(f3_rci, csr_mie,      5'h0a, 2'd1, 32'd0, 8'h00);
        add_row(f3_rwi, csr_mtvec,    5'h1f, 2'd2, 32'd0, 8'h00);
        add_row(f3_rsi, csr_mtvec,    5'd0,  2'd2, 32'd0, 8'h00);
        add_row(f3_rw,  csr_mscratch, 5'd4,  2'd3, $urandom(), 8'h00);
        add_row(f3_rc,  csr_mscratch, 5'd0,  2'd3, 32'hffff_ffff, 8'h00);
        add_row(f3_rw,  csr_mepc,     5'd5,  2'd0, $urandom(), 8'h00);
        add_row(f3_rs,  csr_mepc,     5'd6,  2'd0, $urandom(), 8'h00);
        add_row(f3_rs,  csr_mie,      5'd0,  2'd1, 32'd0, 8'h00);
        add_row(f3_rs,  csr_mepc,     5'd0,  2'd0, 32'd0, 8'h00);
        // per-warp fp state
        add_row(f3_rw,  csr_fcsr,     5'd7,  2'd0, $urandom(), 8'h00);
        add_row(f3_rw,  csr_fcsr,     5'd8,  2'd1, $urandom(), 8'h00);
        add_row(f3_rs,  csr_frm,      5'd0,  2'd0, 32'd0, 8'h00);
        add_row(f3_rs,  csr_fflags,   5'd0,  2'd0, 32'd0, 8'h00);
        add_row(f3_rwi, csr_frm,      5'h05, 2'd2, 32'd0, 8'h00);
        add_row(f3_rwi, csr_fflags,   5'h1b, 2'd3, 32'd0, 8'h00);
        add_row(f3_rs,  csr_fcsr,     5'd0,  2'd2, 32'd0, 8'h00);
        add_row(f3_rs,  csr_fcsr,     5'd0,  2'd1, 32'd0, 8'h00);
        // fpu flag writes, then a same-edge clash on warp 1
        add_row(f3_rs,  csr_fflags,   5'd0,  2'd0, 32'd0, {1'b1, 2'd2, 5'h11});
        add_row(f3_rs,  csr_fflags,   5'd0,  2'd2, 32'd0, 8'h00);
        add_row(f3_rs,  csr_fcsr,     5'd0,  2'd3, 32'd0, 8'h00);
        add_row(f3_rwi, csr_fflags,   5'h03, 2'd1, 32'd0, 8'h00);
        add_row(f3_rs,  csr_fcsr,     5'd0,  2'd1, 32'd0, {1'b1, 2'd1, 5'h1c});
        // constants
        add_row(f3_rs,  csr_misa,     5'd0,  2'd0, 32'd0, 8'h00);
        add_row(f3_rs,  csr_nw,       5'd0,  2'd1, 32'd0, 8'h00);
        for (int w = 0; w < num_warps; w++) begin
            add_row(f3_rs,  csr_wid,      5'd0,  2'(w), 32'd0, 8'h00);
            add_row(f3_rs,  csr_gwid,     5'd0,  2'(w), 32'd0, 8'h00);
            add_row(f3_rs,  csr_mhartid,  5'd0,  2'(w), 32'd0, 8'h00);
        end
        // illegal requests
        add_row(f3_rw,  csr_misa,     5'd1,  2'd0, $urandom(), 8'h00);
        add_row(f3_rwi, csr_mcycle,   5'h03, 2'd0, 32'd0, 8'h00);
        add_row(f3_rw,  csr_minstret_h, 5'd2, 2'd1, $urandom(), 8'h00);
        add_row(f3_rs,  12'h7c0,      5'd0,  2'd0, 32'd0, 8'h00);
        add_row(3'd0,   csr_mscratch, 5'd1,  2'd3, $urandom(), 8'h00);
        add_row(3'd4,   csr_mscratch, 5'd1,  2'd3, $urandom(), 8'h00);
        add_row(f3_rs,  csr_mscratch, 5'd0,  2'd3, 32'd0, 8'h00);
        // mcycle stays put while busy is low
        add_row(f3_rs,  csr_mcycle,   5'd0,  2'd0, 32'd0, 8'h00);
        add_row(f3_rs,  csr_mcycle,   5'd0,  2'd0, 32'd0, 8'h00);
    endtask

    task automatic read_csr(input logic [11:0] a, output logic [31:0] d, output int at);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = {a, 5'd0, f3_rs, 5'd1, opcode_system};
        at          = cycles;
        @(negedge clk);
        instr_valid = 1'b0;
        while (!rsp_valid)
            @(negedge clk);
        if (rsp_illegal) begin
            errors++;
            $display("the read of csr %h came back as illegal", a);
        end
        d = rsp_data;
    endtask

    always @(negedge clk) begin
        if (table_phase && rsp_valid) begin
            if (pending.size() == 0) begin
                errors++;
                $display("a response came back at %0t with no request outstanding", $time);
            end else begin
                mon_row   = pending.pop_front();
                mon_issue = issued.pop_front();
                mon_errs  = errors;
                check("rsp latency", 32'(cycles - mon_issue), 32'd2);
                check("rsp_data", rsp_data, exp_old[mon_row]);
                check("rsp_illegal", {31'd0, rsp_illegal}, {31'd0, exp_ill[mon_row]});
                check("rsp_wid", {30'd0, rsp_wid}, {30'd0, r_wid[mon_row]});
                check("rsp_rd", {27'd0, rsp_rd}, {27'd0, 5'(mon_row)});
                end_test($sformatf("row %0d addr %h wid %0d", mon_row, r_addr[mon_row],
                                   r_wid[mon_row]), mon_errs);
            end
        end
    end

    initial begin
        logic [31:0] d1, d2;
        int at1, at2, sum, errs_before;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        instr_wid    = '0;
        rs1_data     = '0;
        fpu_valid    = 1'b0;
        fpu_wid      = '0;
        fpu_fflags   = '0;
        fpu_read_wid = '0;
        commit_valid = 1'b0;
        commit_size  = '0;
        busy         = 1'b0;
        void'($urandom(32'hca5a_8371));
        build_table();
        run_model();
        cycle_limit = n_rows + counter_cycles + 20;
        repeat (4) @(negedge clk);
        reset       = 1'b0;
        table_phase = 1'b1;
        for (int t = 0; t < n_rows; t++) begin
            @(negedge clk);
            instr_valid = 1'b1;
            instr       = {r_addr[t], r_src[t], r_f3[t], 5'(t), opcode_system};
            instr_wid   = r_wid[t];
            rs1_data    = r_rs1[t];
            fpu_valid   = r_fpu[t][7];
            fpu_wid     = r_fpu[t][6:5];
            fpu_fflags  = r_fpu[t][4:0];
            pending.push_back(t);
            issued.push_back(cycles);
        end
        @(negedge clk);
        instr_valid = 1'b0;
        fpu_valid   = 1'b0;
        while (pending.size() != 0)
            @(negedge clk);
        table_phase = 1'b0;

        errs_before = errors;
        for (int w = 0; w < num_warps; w++) begin
            fpu_read_wid = 2'(w);
            #10;
            check("fpu_frm", {29'd0, fpu_frm}, {29'd0, fcsr_m[w][7:5]});
        end
        end_test("fpu_frm side port", errs_before);

        errs_before = errors;
        sum = 0;
        for (int k = 0; k < 5; k++) begin
            @(negedge clk);
            commit_valid = 1'b1;
            commit_size  = 3'($urandom() % 8);
            sum += commit_size;
        end
        @(negedge clk);
        commit_valid = 1'b0;
        read_csr(csr_minstret, d1, at1);
        check("minstret", d1, 32'(sum));
        read_csr(csr_minstret_h, d2, at2);
        check("minstret_h", d2, 32'd0);
        end_test("minstret after commits", errs_before);

        errs_before = errors;
        @(negedge clk);
        busy = 1'b1;
        read_csr(csr_mcycle, d1, at1);
        read_csr(csr_mcycle, d2, at2);
        busy = 1'b0;
        check("mcycle step", d2 - d1, 32'(at2 - at1));
        end_test("mcycle while busy", errs_before);

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule
